//--- verilog.f
+incdir+.
oled_pkg.sv
oled_slot_if.sv
oled_pixel_if.sv
oled_sequencer.sv
oled_frame_buffer.sv
oled_i2c_formatter.sv
oled_stream_top.sv
tb_oled_stream.sv

//--- oled_trace.txt
// words 0-31: init table, command byte in the two upper digits, continue flag in the last
// words 32-37: scenarios, life in the two upper digits, sel in the last
AE1 D51 801 A80 1F0 D31 001 401
8D0 140 201 001 A11 C80 DA0 020
810 8F0 D90 F10 DB1 401 A41 A61
2E1 AF0 221 001 FF1 211 000 7F0
000 0A1 1E2 2D3 3C0 641

//--- tb_oled_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_oled_stream;

    localparam int FRAMES = 6;
    localparam int REQS_PER_FRAME = 544;
    localparam int TIMEOUT_CYCLES = FRAMES * REQS_PER_FRAME * 4 + 2000;
    // one heart, seven columns, leftmost byte first
    localparam logic [55:0] HEART_FULL = 56'h0E1D3F7E3F1F0E;
    localparam logic [55:0] HEART_HALF = 56'h0E1D3F7E000000;

    typedef struct packed {
        logic [7:0]  control;
        logic [7:0]  data;
        logic        cont;
        logic        done;
        int unsigned cycle;
    } exp_byte_t;

    logic       clk;
    logic       reset;
    logic       frame_start;
    logic       byte_req;
    logic [6:0] life;
    logic [1:0] sel;
    logic       load_we;
    logic [8:0] load_addr;
    logic [7:0] load_data;
    logic       byte_valid;
    logic [6:0] byte_addr;
    logic       byte_rw;
    logic [7:0] byte_control;
    logic [7:0] byte_data;
    logic       byte_continue;
    logic       frame_done;

    logic [11:0] trace_mem [0:37];
    logic [7:0]  bitmap [0:511];
    exp_byte_t   expected_q [$];
    exp_byte_t   head;
    int unsigned cycle = 0;
    int          error_count = 0;
    int          bytes_seen = 0;
    int unsigned seed_sink;

    oled_stream_top oled_stream_top_inst (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .byte_req      (byte_req),
        .life          (life),
        .sel           (sel),
        .load_we       (load_we),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .byte_valid    (byte_valid),
        .byte_addr     (byte_addr),
        .byte_rw       (byte_rw),
        .byte_control  (byte_control),
        .byte_data     (byte_data),
        .byte_continue (byte_continue),
        .frame_done    (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, expected,
                     cycle);
        end
    endtask

    // bitmap byte after the heart and underline overlays
    function automatic logic [7:0] expected_pixel(input int idx, input int life_v,
                                                  input int sel_v, input logic [7:0] raw);
        int         halves;
        int         col;
        int         lo;
        int         hi;
        logic [7:0] v;
        v = raw;
        if (life_v > 83) halves = 6;
        else if (life_v > 67) halves = 5;
        else if (life_v > 50) halves = 4;
        else if (life_v > 33) halves = 3;
        else if (life_v > 16) halves = 2;
        else if (life_v > 0) halves = 1;
        else halves = 0;
        for (int k = 0; k < 3; k++) begin
            col = idx - (483 + 9 * k);
            if (col >= 0 && col < 7) begin
                if (halves >= 2 * k + 2) v = HEART_FULL[55 - 8 * col -: 8];
                else if (halves == 2 * k + 1) v = HEART_HALF[55 - 8 * col -: 8];
                else v = 8'h00;
            end
        end
        case (sel_v)
            0: begin
                lo = 138;
                hi = 148;
            end
            1: begin
                lo = 159;
                hi = 185;
            end
            2: begin
                lo = 195;
                hi = 222;
            end
            default: begin
                lo = 234;
                hi = 244;
            end
        endcase
        if (idx >= 128 && idx <= 255) v[3] = (idx >= lo) && (idx <= hi);
        return v;
    endfunction

    task automatic send_request(input exp_byte_t e);
        int gap;
        e.cycle = cycle;
        expected_q.push_back(e);
        byte_req = 1'b1;
        @(negedge clk);
        byte_req = 1'b0;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk);
    endtask

    // requests while idle must stay silent
    task automatic idle_requests(input int count);
        repeat (count) begin
            byte_req = 1'b1;
            @(negedge clk);
            byte_req = 1'b0;
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
    endtask

    task automatic run_frame(input int scen);
        exp_byte_t   e;
        logic [11:0] s;
        s = trace_mem[32 + scen];
        life = s[10:4];
        sel = s[1:0];
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        for (int i = 0; i < 32; i++) begin
            e.control = 8'h00;
            e.data = trace_mem[i][11:4];
            e.cont = trace_mem[i][0];
            e.done = 1'b0;
            send_request(e);
        end
        for (int i = 0; i < 512; i++) begin
            e.control = 8'h40;
            e.data = expected_pixel(i, int'(life), int'(sel), bitmap[i]);
            e.cont = 1'b0;
            e.done = (i == 511);
            send_request(e);
        end
        while (expected_q.size() != 0) @(negedge clk);
        idle_requests(2);
    endtask

    // scoreboard against the queue of requested bytes
    always @(negedge clk) begin
        if (!reset && byte_valid) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("unexpected output byte with no request pending at cycle %0d", cycle);
            end else begin
                head = expected_q.pop_front();
                check_value("byte_addr", byte_addr, 7'h3C);
                check_value("byte_rw", byte_rw, 1'b0);
                check_value("byte_control", byte_control, head.control);
                check_value("byte_data", byte_data, head.data);
                check_value("byte_continue", byte_continue, head.cont);
                check_value("frame_done", frame_done, head.done);
                check_value("latency", cycle - head.cycle, 3);
                bytes_seen++;
            end
        end else if (!reset) begin
            check_value("frame_done", frame_done, 1'b0);
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset = 1'b1;
        frame_start = 1'b0;
        byte_req = 1'b0;
        life = '0;
        sel = '0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed_sink = $urandom(32'h1b1b3883);
        $readmemh("oled_trace.txt", trace_mem);
        if (^trace_mem[37] === 1'bx) begin
            error_count++;
            $display("trace file oled_trace.txt could not be read completely");
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int a = 0; a < 512; a++) begin
            load_we = 1'b1;
            load_addr = a[8:0];
            load_data = 8'($urandom);
            bitmap[a] = load_data;
            @(negedge clk);
        end
        load_we = 1'b0;
        idle_requests(3);
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        if (bytes_seen != FRAMES * REQS_PER_FRAME) begin
            error_count++;
            $display("only %0d of %0d bytes came out", bytes_seen, FRAMES * REQS_PER_FRAME);
        end
        $display("errors: %0d, bytes checked: %0d", error_count, bytes_seen);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- oled_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

module oled_stream_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_start,
    input  logic                    byte_req,
    input  logic [`OLED_LIFE_W-1:0] life,
    input  logic [`OLED_SEL_W-1:0]  sel,
    input  logic                    load_we,
    input  logic [`OLED_IDX_W-1:0]  load_addr,
    input  logic [7:0]              load_data,
    output logic                    byte_valid,
    output logic [6:0]              byte_addr,
    output logic                    byte_rw,
    output logic [7:0]              byte_control,
    output logic [7:0]              byte_data,
    output logic                    byte_continue,
    output logic                    frame_done
);

    oled_slot_if  slot_bus ();
    oled_pixel_if pixel_bus ();

    // request to slot
    oled_sequencer oled_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .byte_req    (byte_req),
        .slot        (slot_bus.producer)
    );

    // slot to payload with game overlays
    oled_frame_buffer oled_frame_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .life      (life),
        .sel       (sel),
        .slot      (slot_bus.consumer),
        .pixel     (pixel_bus.producer)
    );

    oled_i2c_formatter oled_i2c_formatter_inst (
        .clk           (clk),
        .reset         (reset),
        .pixel         (pixel_bus.consumer),
        .byte_valid    (byte_valid),
        .byte_addr     (byte_addr),
        .byte_rw       (byte_rw),
        .byte_control  (byte_control),
        .byte_data     (byte_data),
        .byte_continue (byte_continue),
        .frame_done    (frame_done)
    );

endmodule

`default_nettype wire

//--- oled_i2c_formatter.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

module oled_i2c_formatter (
    input  logic           clk,
    input  logic           reset,
    oled_pixel_if.consumer pixel,
    output logic           byte_valid,
    output logic [6:0]     byte_addr,
    output logic           byte_rw,
    output logic [7:0]     byte_control,
    output logic [7:0]     byte_data,
    output logic           byte_continue,
    output logic           frame_done
);

    // {command byte, continuation flag}
    logic [8:0] init_entry;

    always_comb begin
        case (pixel.index[4:0])
            5'd0:  init_entry = {8'hAE, 1'b1};
            5'd1:  init_entry = {8'hD5, 1'b1};
            5'd2:  init_entry = {8'h80, 1'b1};
            5'd3:  init_entry = {8'hA8, 1'b0};
            5'd4:  init_entry = {8'h1F, 1'b0};
            5'd5:  init_entry = {8'hD3, 1'b1};
            5'd6:  init_entry = {8'h00, 1'b1};
            5'd7:  init_entry = {8'h40, 1'b1};
            5'd8:  init_entry = {8'h8D, 1'b0};
            5'd9:  init_entry = {8'h14, 1'b0};
            // horizontal addressing, remap and scan direction
            5'd10: init_entry = {8'h20, 1'b1};
            5'd11: init_entry = {8'h00, 1'b1};
            5'd12: init_entry = {8'hA1, 1'b1};
            5'd13: init_entry = {8'hC8, 1'b0};
            5'd14: init_entry = {8'hDA, 1'b0};
            5'd15: init_entry = {8'h02, 1'b0};
            5'd16: init_entry = {8'h81, 1'b0};
            5'd17: init_entry = {8'h8F, 1'b0};
            5'd18: init_entry = {8'hD9, 1'b0};
            5'd19: init_entry = {8'hF1, 1'b0};
            5'd20: init_entry = {8'hDB, 1'b1};
            5'd21: init_entry = {8'h40, 1'b1};
            5'd22: init_entry = {8'hA4, 1'b1};
            5'd23: init_entry = {8'hA6, 1'b1};
            5'd24: init_entry = {8'h2E, 1'b1};
            5'd25: init_entry = {8'hAF, 1'b0};
            // page and column window for the frame
            5'd26: init_entry = {8'h22, 1'b1};
            5'd27: init_entry = {8'h00, 1'b1};
            5'd28: init_entry = {8'hFF, 1'b1};
            5'd29: init_entry = {8'h21, 1'b1};
            5'd30: init_entry = {8'h00, 1'b0};
            5'd31: init_entry = {8'h7F, 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            byte_valid <= pixel.valid;
            frame_done <= pixel.valid && pixel.last;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel.valid) begin
            byte_addr <= `OLED_I2C_ADDR;
            byte_rw   <= 1'b0;
            if (pixel.kind == oled_pkg::KIND_CMD) begin
                byte_control  <= `OLED_CTRL_CMD;
                byte_data     <= init_entry[8:1];
                byte_continue <= init_entry[0];
            end else begin
                byte_control  <= `OLED_CTRL_DATA;
                byte_data     <= pixel.data;
                byte_continue <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- oled_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

module oled_frame_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_we,
    input  logic [`OLED_IDX_W-1:0] load_addr,
    input  logic [7:0]             load_data,
    input  logic [`OLED_LIFE_W-1:0] life,
    input  logic [`OLED_SEL_W-1:0] sel,
    oled_slot_if.consumer          slot,
    oled_pixel_if.producer         pixel
);

    logic [7:0]             mem [0:`OLED_FRAME_BYTES-1];
    logic [7:0]             raw_byte;
    logic [2:0]             half_hearts;
    logic [`OLED_IDX_W-1:0] heart_rel;
    logic [`OLED_IDX_W-1:0] bar_lo;
    logic [`OLED_IDX_W-1:0] bar_hi;
    logic [7:0]             shown_byte;

    function automatic logic [7:0] heart_col(input logic [2:0] col);
        case (col)
            3'd0: heart_col = 8'h0E;
            3'd1: heart_col = 8'h1D;
            3'd2: heart_col = 8'h3F;
            3'd3: heart_col = 8'h7E;
            3'd4: heart_col = 8'h3F;
            3'd5: heart_col = 8'h1F;
            3'd6: heart_col = 8'h0E;
            default: heart_col = 8'h00;
        endcase
    endfunction

    // host port, a same-cycle read sees the old byte
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (slot.valid && slot.kind == oled_pkg::KIND_DATA) begin
            raw_byte <= mem[slot.index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel.valid <= 1'b0;
        end else begin
            pixel.valid <= slot.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (slot.valid) begin
            pixel.kind  <= slot.kind;
            pixel.index <= slot.index;
            pixel.last  <= slot.last;
        end
    end

    // life to half hearts, anything past 100 stays at 6
    always_comb begin
        if (life > `OLED_LIFE_HALF6) half_hearts = 3'd6;
        else if (life > `OLED_LIFE_HALF5) half_hearts = 3'd5;
        else if (life > `OLED_LIFE_HALF4) half_hearts = 3'd4;
        else if (life > `OLED_LIFE_HALF3) half_hearts = 3'd3;
        else if (life > `OLED_LIFE_HALF2) half_hearts = 3'd2;
        else if (life > `OLED_LIFE_HALF1) half_hearts = 3'd1;
        else half_hearts = 3'd0;
    end

    always_comb begin
        case (sel)
            2'd0: begin
                bar_lo = `OLED_IDX_W'(`OLED_SEL0_LO);
                bar_hi = `OLED_IDX_W'(`OLED_SEL0_HI);
            end
            2'd1: begin
                bar_lo = `OLED_IDX_W'(`OLED_SEL1_LO);
                bar_hi = `OLED_IDX_W'(`OLED_SEL1_HI);
            end
            2'd2: begin
                bar_lo = `OLED_IDX_W'(`OLED_SEL2_LO);
                bar_hi = `OLED_IDX_W'(`OLED_SEL2_HI);
            end
            default: begin
                bar_lo = `OLED_IDX_W'(`OLED_SEL3_LO);
                bar_hi = `OLED_IDX_W'(`OLED_SEL3_HI);
            end
        endcase
    end

    always_comb begin
        shown_byte = raw_byte;
        heart_rel  = '0;
        for (int k = 0; k < `OLED_HEART_COUNT; k++) begin
            // wraps high below the slot, so one compare bounds both sides
            heart_rel = pixel.index
                      - `OLED_IDX_W'(`OLED_HEART_BASE + k * `OLED_HEART_PITCH);
            if (heart_rel < `OLED_HEART_W) begin
                if (half_hearts >= 2 * k + 2) begin
                    shown_byte = heart_col(heart_rel[2:0]);
                end else if (half_hearts == 2 * k + 1 && heart_rel < `OLED_HEART_HALF_W) begin
                    shown_byte = heart_col(heart_rel[2:0]);
                end else begin
                    shown_byte = 8'h00;
                end
            end
        end
        if (pixel.index >= `OLED_BAR_LO && pixel.index <= `OLED_BAR_HI) begin
            shown_byte[3] = (pixel.index >= bar_lo) && (pixel.index <= bar_hi);
        end
    end

    assign pixel.data = (pixel.kind == oled_pkg::KIND_DATA) ? shown_byte : 8'h00;

endmodule

`default_nettype wire

//--- oled_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

module oled_sequencer (
    input  logic          clk,
    input  logic          reset,
    input  logic          frame_start,
    input  logic          byte_req,
    oled_slot_if.producer slot
);

    localparam logic [`OLED_IDX_W-1:0] INIT_LAST = `OLED_IDX_W'(`OLED_INIT_LEN - 1);
    localparam logic [`OLED_IDX_W-1:0] FRAME_LAST = `OLED_IDX_W'(`OLED_FRAME_BYTES - 1);

    oled_pkg::oled_phase_t  phase;
    logic [`OLED_IDX_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= oled_pkg::PH_IDLE;
            count <= '0;
        end else begin
            case (phase)
                oled_pkg::PH_IDLE: begin
                    if (frame_start) begin
                        phase <= oled_pkg::PH_INIT;
                        count <= '0;
                    end
                end
                oled_pkg::PH_INIT: begin
                    if (byte_req) begin
                        if (count == INIT_LAST) begin
                            phase <= oled_pkg::PH_FRAME;
                            count <= '0;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                oled_pkg::PH_FRAME: begin
                    if (byte_req) begin
                        if (count == FRAME_LAST) begin
                            phase <= oled_pkg::PH_IDLE;
                            count <= '0;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: begin
                    phase <= oled_pkg::PH_IDLE;
                end
            endcase
        end
    end

    // requests in idle are dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            slot.valid <= 1'b0;
        end else begin
            slot.valid <= byte_req && (phase != oled_pkg::PH_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (byte_req) begin
            slot.kind  <= (phase == oled_pkg::PH_FRAME) ? oled_pkg::KIND_DATA
                                                        : oled_pkg::KIND_CMD;
            slot.index <= count;
            slot.last  <= (phase == oled_pkg::PH_FRAME) && (count == FRAME_LAST);
        end
    end

endmodule

`default_nettype wire

//--- oled_pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

// resolved payload, frame buffer to formatter
interface oled_pixel_if;

    logic                   valid;
    oled_pkg::oled_kind_t   kind;
    logic [`OLED_IDX_W-1:0] index;
    // bitmap byte after overlays, zero for commands
    logic [7:0]             data;
    logic                   last;

    modport producer (output valid, kind, index, data, last);
    modport consumer (input valid, kind, index, data, last);

endinterface

`default_nettype wire

//--- oled_slot_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "oled_params.svh"

// one byte slot, sequencer to frame buffer
interface oled_slot_if;

    logic                   valid;
    oled_pkg::oled_kind_t   kind;
    logic [`OLED_IDX_W-1:0] index;
    // frame index 511
    logic                   last;

    modport producer (output valid, kind, index, last);
    modport consumer (input valid, kind, index, last);

endinterface

`default_nettype wire

//--- oled_pkg.sv
`default_nettype none

package oled_pkg;

    // sequencer phase
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_INIT  = 2'd1,
        PH_FRAME = 2'd2
    } oled_phase_t;

    // byte kind, selects the control byte
    typedef enum logic {
        KIND_CMD  = 1'b0,
        KIND_DATA = 1'b1
    } oled_kind_t;

endpackage

`default_nettype wire

//--- oled_params.svh
`ifndef OLED_PARAMS_SVH
`define OLED_PARAMS_SVH

// bus address and control bytes
`define OLED_I2C_ADDR 7'h3C
`define OLED_CTRL_CMD 8'h00
`define OLED_CTRL_DATA 8'h40

// stream lengths
`define OLED_INIT_LEN 32
`define OLED_FRAME_BYTES 512
`define OLED_IDX_W 9

// game inputs
`define OLED_LIFE_W 7
`define OLED_SEL_W 2

// life above HALFn shows n half hearts
`define OLED_LIFE_HALF1 0
`define OLED_LIFE_HALF2 16
`define OLED_LIFE_HALF3 33
`define OLED_LIFE_HALF4 50
`define OLED_LIFE_HALF5 67
`define OLED_LIFE_HALF6 83

// hearts on the bottom page
`define OLED_HEART_BASE 483
`define OLED_HEART_PITCH 9
`define OLED_HEART_W 7
`define OLED_HEART_HALF_W 4
`define OLED_HEART_COUNT 3

// icon row underline, bit 3 of page 1
`define OLED_BAR_LO 128
`define OLED_BAR_HI 255
`define OLED_SEL0_LO 138
`define OLED_SEL0_HI 148
`define OLED_SEL1_LO 159
`define OLED_SEL1_HI 185
`define OLED_SEL2_LO 195
`define OLED_SEL2_HI 222
`define OLED_SEL3_LO 234
`define OLED_SEL3_HI 244

`endif
